// File: logic/decode_pkg.sv
package decode_pkg;

    // window geometry
    localparam int window_bytes = 16;

    typedef logic [7:0] byte_t;

    // field length in bytes, 0 to 4
    typedef logic [2:0] field_len_t;

    // instruction length or byte position within the window
    typedef logic [3:0] instr_len_t;

    typedef logic [2:0] seg_id_t;

    // segment register ids
    localparam seg_id_t seg_es = 3'd0;
    localparam seg_id_t seg_cs = 3'd1;
    localparam seg_id_t seg_ss = 3'd2;
    localparam seg_id_t seg_ds = 3'd3;
    localparam seg_id_t seg_fs = 3'd4;
    localparam seg_id_t seg_gs = 3'd5;

    // operand size and repeat prefixes
    localparam byte_t pfx_opsize = 8'h66;
    localparam byte_t pfx_repne = 8'hF2;
    localparam byte_t pfx_rep = 8'hF3;

    // segment override prefixes
    localparam byte_t pfx_es = 8'h26;
    localparam byte_t pfx_cs = 8'h2E;
    localparam byte_t pfx_ss = 8'h36;
    localparam byte_t pfx_ds = 8'h3E;
    localparam byte_t pfx_fs = 8'h64;
    localparam byte_t pfx_gs = 8'h65;

    // two-byte opcode escape
    localparam byte_t op_escape = 8'h0F;

endpackage

// File: logic/decode_if.sv
// located prefix and opcode bytes
interface opcode_if;
    logic [15:0] opcode;
    logic opcode_size;
    logic [1:0] prefix_count;
    logic operand_override;
    logic repeat_prefix;
    logic segment_override;
    decode_pkg::seg_id_t seg_id;
    decode_pkg::byte_t modrm_byte;
    decode_pkg::byte_t sib_byte;

    modport src (
        output opcode, opcode_size, prefix_count, operand_override, repeat_prefix,
        output segment_override, seg_id, modrm_byte, sib_byte
    );
    modport dst (
        input opcode, opcode_size, prefix_count, operand_override, repeat_prefix,
        input segment_override, seg_id, modrm_byte, sib_byte
    );
endinterface

// modrm, sib and displacement presence
interface addr_if;
    logic modrm_present;
    logic sib_present;
    logic disp_present;
    decode_pkg::field_len_t disp_len;

    modport src (output modrm_present, sib_present, disp_present, disp_len);
    modport dst (input modrm_present, sib_present, disp_present, disp_len);
endinterface

// immediate and relative offset presence
interface imm_if;
    logic imm_present;
    decode_pkg::field_len_t imm_len;
    logic offset_present;
    decode_pkg::field_len_t offset_len;

    modport src (output imm_present, imm_len, offset_present, offset_len);
    modport dst (input imm_present, imm_len, offset_present, offset_len);
endinterface

// File: logic/opcode_locator.sv
module opcode_locator #(
    parameter int prefix_slots = 3
) (
    input logic [8*decode_pkg::window_bytes-1:0] ir,
    opcode_if.src opc
);

    decode_pkg::byte_t win [decode_pkg::window_bytes];

    logic in_run;
    logic [2:0] run_len;
    logic op_ovr;
    logic rep;
    logic seg_ovr;
    decode_pkg::seg_id_t seg;

    logic [3:0] op_pos;
    logic [3:0] modrm_pos;
    decode_pkg::byte_t first_byte;
    logic escape;

    function automatic logic is_segment(input decode_pkg::byte_t b);
        return b inside {decode_pkg::pfx_es, decode_pkg::pfx_cs, decode_pkg::pfx_ss,
                         decode_pkg::pfx_ds, decode_pkg::pfx_fs, decode_pkg::pfx_gs};
    endfunction

    function automatic logic is_prefix(input decode_pkg::byte_t b);
        return is_segment(b)
            || b inside {decode_pkg::pfx_opsize, decode_pkg::pfx_repne, decode_pkg::pfx_rep};
    endfunction

    function automatic decode_pkg::seg_id_t seg_of(input decode_pkg::byte_t b);
        case (b)
            decode_pkg::pfx_cs: return decode_pkg::seg_cs;
            decode_pkg::pfx_ss: return decode_pkg::seg_ss;
            decode_pkg::pfx_ds: return decode_pkg::seg_ds;
            decode_pkg::pfx_fs: return decode_pkg::seg_fs;
            decode_pkg::pfx_gs: return decode_pkg::seg_gs;
            default: return decode_pkg::seg_es;
        endcase
    endfunction

    // byte 0 sits in the top of ir
    for (genvar i = 0; i < decode_pkg::window_bytes; i++) begin : g_unpack
        assign win[i] = ir[8*(decode_pkg::window_bytes-1-i) +: 8];
    end

    // leading prefix run, later segment prefixes override earlier ones
    always_comb begin
        in_run = 1'b1;
        run_len = '0;
        op_ovr = 1'b0;
        rep = 1'b0;
        seg_ovr = 1'b0;
        seg = '0;
        for (int i = 0; i < prefix_slots; i++) begin
            if (in_run && is_prefix(win[i])) begin
                run_len = run_len + 3'd1;
                if (win[i] == decode_pkg::pfx_opsize) begin
                    op_ovr = 1'b1;
                end
                if (win[i] == decode_pkg::pfx_rep || win[i] == decode_pkg::pfx_repne) begin
                    rep = 1'b1;
                end
                if (is_segment(win[i])) begin
                    seg_ovr = 1'b1;
                    seg = seg_of(win[i]);
                end
            end else begin
                in_run = 1'b0;
            end
        end
    end

    assign op_pos = {1'b0, run_len};
    assign first_byte = win[op_pos];
    assign escape = (first_byte == decode_pkg::op_escape);
    assign modrm_pos = op_pos + (escape ? 4'd2 : 4'd1);

    assign opc.opcode = escape ? {first_byte, win[op_pos + 4'd1]} : {8'h00, first_byte};
    assign opc.opcode_size = escape;
    assign opc.prefix_count = run_len[1:0];
    assign opc.operand_override = op_ovr;
    assign opc.repeat_prefix = rep;
    assign opc.segment_override = seg_ovr;
    assign opc.seg_id = seg;
    assign opc.modrm_byte = win[modrm_pos];
    assign opc.sib_byte = win[modrm_pos + 4'd1];

endmodule

// File: logic/addressing_decoder.sv
module addressing_decoder (
    opcode_if.dst opc,
    addr_if.src addr
);

    decode_pkg::byte_t op;
    logic has_modrm;
    logic [1:0] mod_bits;
    logic [2:0] rm_bits;
    logic [2:0] sib_base;
    logic has_sib;
    decode_pkg::field_len_t disp;

    assign op = opc.opcode[7:0];
    assign mod_bits = opc.modrm_byte[7:6];
    assign rm_bits = opc.modrm_byte[2:0];
    assign sib_base = opc.sib_byte[2:0];

    always_comb begin
        if (opc.opcode_size) begin
            has_modrm = op inside {8'hAF, 8'hB6, 8'hB7};
        end else begin
            // alu group r/m forms, then the listed one-byte opcodes
            has_modrm = (op <= 8'h3F && op[2:0] < 3'd4)
                     || (op inside {[8'h80:8'h8B], 8'hC6, 8'hC7, 8'hF6, 8'hF7, 8'hFF});
        end
    end

    assign has_sib = has_modrm && mod_bits != 2'd3 && rm_bits == 3'd4;

    // 32-bit addressing displacement sizes
    always_comb begin
        disp = 3'd0;
        if (has_modrm) begin
            case (mod_bits)
                2'd0: begin
                    if (rm_bits == 3'd5 || (has_sib && sib_base == 3'd5)) begin
                        disp = 3'd4;
                    end
                end
                2'd1: disp = 3'd1;
                2'd2: disp = 3'd4;
                default: disp = 3'd0;
            endcase
        end
    end

    assign addr.modrm_present = has_modrm;
    assign addr.sib_present = has_sib;
    assign addr.disp_present = (disp != 3'd0);
    assign addr.disp_len = disp;

endmodule

// File: logic/immediate_decoder.sv
module immediate_decoder (
    opcode_if.dst opc,
    imm_if.src imm
);

    decode_pkg::byte_t op;
    decode_pkg::field_len_t z_len;
    decode_pkg::field_len_t imm_sz;
    decode_pkg::field_len_t off_sz;

    assign op = opc.opcode[7:0];

    // z operand is word sized under 0x66
    assign z_len = opc.operand_override ? 3'd2 : 3'd4;

    always_comb begin
        imm_sz = 3'd0;
        off_sz = 3'd0;
        if (opc.opcode_size) begin
            // jcc rel16/32
            if (op[7:4] == 4'h8) begin
                off_sz = z_len;
            end
        end else if (op <= 8'h3F && op[2:0] == 3'd4) begin
            imm_sz = 3'd1;
        end else if (op <= 8'h3F && op[2:0] == 3'd5) begin
            imm_sz = z_len;
        end else begin
            case (op) inside
                [8'hB0:8'hB7], 8'h80, 8'h83, 8'hC6, 8'h6A: begin
                    imm_sz = 3'd1;
                end
                [8'hB8:8'hBF], 8'h81, 8'hC7, 8'h68: begin
                    imm_sz = z_len;
                end
                // short jumps
                [8'h70:8'h7F], 8'hEB: begin
                    off_sz = 3'd1;
                end
                // near call and jmp
                8'hE8, 8'hE9: begin
                    off_sz = z_len;
                end
                default: begin
                    imm_sz = 3'd0;
                    off_sz = 3'd0;
                end
            endcase
        end
    end

    assign imm.imm_present = (imm_sz != 3'd0);
    assign imm.imm_len = imm_sz;
    assign imm.offset_present = (off_sz != 3'd0);
    assign imm.offset_len = off_sz;

endmodule

// File: logic/length_combiner.sv
module length_combiner (
    input logic clk,
    input logic rst_n,
    input logic instr_valid,
    input logic [31:0] eip,
    input logic [15:0] cs,
    input logic [8*decode_pkg::window_bytes-1:0] ir,
    opcode_if.dst opc,
    addr_if.dst addr,
    imm_if.dst imm,
    output logic decode_valid,
    output logic [31:0] eip_out,
    output logic [15:0] cs_out,
    output logic [8*decode_pkg::window_bytes-1:0] ir_out,
    output logic [15:0] opcode,
    output logic opcode_size,
    output logic [1:0] prefix_count,
    output logic operand_override,
    output logic repeat_prefix,
    output logic segment_override,
    output decode_pkg::seg_id_t seg_id,
    output decode_pkg::byte_t modrm,
    output decode_pkg::byte_t sib,
    output logic modrm_present,
    output logic sib_present,
    output logic disp_present,
    output decode_pkg::field_len_t disp_len,
    output logic imm_present,
    output decode_pkg::field_len_t imm_len,
    output logic offset_present,
    output decode_pkg::field_len_t offset_len,
    output decode_pkg::instr_len_t disp_sel,
    output decode_pkg::instr_len_t imm_sel,
    output decode_pkg::instr_len_t instr_length
);

    decode_pkg::instr_len_t opc_len;
    decode_pkg::instr_len_t next_disp_sel;
    decode_pkg::instr_len_t next_imm_sel;
    decode_pkg::instr_len_t next_length;

    assign opc_len = opc.opcode_size ? 4'd2 : 4'd1;

    // prefixes, opcode, then modrm and sib ahead of the displacement
    assign next_disp_sel = {2'b00, opc.prefix_count} + opc_len
                         + {3'b000, addr.modrm_present} + {3'b000, addr.sib_present};
    assign next_imm_sel = next_disp_sel + {1'b0, addr.disp_len};

    // immediate and offset never both present, they share imm_sel
    assign next_length = next_imm_sel + {1'b0, imm.imm_len} + {1'b0, imm.offset_len};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            decode_valid <= 1'b0;
            eip_out <= '0;
            cs_out <= '0;
            ir_out <= '0;
            opcode <= '0;
            opcode_size <= 1'b0;
            prefix_count <= '0;
            operand_override <= 1'b0;
            repeat_prefix <= 1'b0;
            segment_override <= 1'b0;
            seg_id <= '0;
            modrm <= '0;
            sib <= '0;
            modrm_present <= 1'b0;
            sib_present <= 1'b0;
            disp_present <= 1'b0;
            disp_len <= '0;
            imm_present <= 1'b0;
            imm_len <= '0;
            offset_present <= 1'b0;
            offset_len <= '0;
            disp_sel <= '0;
            imm_sel <= '0;
            instr_length <= '0;
        end else begin
            decode_valid <= instr_valid;
            eip_out <= eip;
            cs_out <= cs;
            ir_out <= ir;
            opcode <= opc.opcode;
            opcode_size <= opc.opcode_size;
            prefix_count <= opc.prefix_count;
            operand_override <= opc.operand_override;
            repeat_prefix <= opc.repeat_prefix;
            segment_override <= opc.segment_override;
            seg_id <= opc.seg_id;
            modrm <= addr.modrm_present ? opc.modrm_byte : 8'h00;
            sib <= addr.sib_present ? opc.sib_byte : 8'h00;
            modrm_present <= addr.modrm_present;
            sib_present <= addr.sib_present;
            disp_present <= addr.disp_present;
            disp_len <= addr.disp_len;
            imm_present <= imm.imm_present;
            imm_len <= imm.imm_len;
            offset_present <= imm.offset_present;
            offset_len <= imm.offset_len;
            disp_sel <= next_disp_sel;
            imm_sel <= next_imm_sel;
            instr_length <= next_length;
        end
    end

endmodule

// File: logic/decode_stage1.sv
module decode_stage1 #(
    parameter int prefix_slots = 3
) (
    input logic clk,
    input logic rst_n,
    input logic instr_valid,
    input logic [8*decode_pkg::window_bytes-1:0] ir,
    input logic [31:0] eip,
    input logic [15:0] cs,
    output logic decode_valid,
    output logic [31:0] eip_out,
    output logic [15:0] cs_out,
    output logic [8*decode_pkg::window_bytes-1:0] ir_out,
    output logic [15:0] opcode,
    output logic opcode_size,
    output logic [1:0] prefix_count,
    output logic operand_override,
    output logic repeat_prefix,
    output logic segment_override,
    output decode_pkg::seg_id_t seg_id,
    output decode_pkg::byte_t modrm,
    output decode_pkg::byte_t sib,
    output logic modrm_present,
    output logic sib_present,
    output logic disp_present,
    output decode_pkg::field_len_t disp_len,
    output logic imm_present,
    output decode_pkg::field_len_t imm_len,
    output logic offset_present,
    output decode_pkg::field_len_t offset_len,
    output decode_pkg::instr_len_t disp_sel,
    output decode_pkg::instr_len_t imm_sel,
    output decode_pkg::instr_len_t instr_length
);

    opcode_if opc_bus ();
    addr_if addr_bus ();
    imm_if imm_bus ();

    opcode_locator #(
        .prefix_slots(prefix_slots)
    ) opcode_locator_i (
        .ir(ir),
        .opc(opc_bus.src)
    );

    // both decoders work off the same located opcode
    addressing_decoder addressing_decoder_i (
        .opc(opc_bus.dst),
        .addr(addr_bus.src)
    );

    immediate_decoder immediate_decoder_i (
        .opc(opc_bus.dst),
        .imm(imm_bus.src)
    );

    length_combiner length_combiner_i (
        .clk(clk),
        .rst_n(rst_n),
        .instr_valid(instr_valid),
        .eip(eip),
        .cs(cs),
        .ir(ir),
        .opc(opc_bus.dst),
        .addr(addr_bus.dst),
        .imm(imm_bus.dst),
        .decode_valid(decode_valid),
        .eip_out(eip_out),
        .cs_out(cs_out),
        .ir_out(ir_out),
        .opcode(opcode),
        .opcode_size(opcode_size),
        .prefix_count(prefix_count),
        .operand_override(operand_override),
        .repeat_prefix(repeat_prefix),
        .segment_override(segment_override),
        .seg_id(seg_id),
        .modrm(modrm),
        .sib(sib),
        .modrm_present(modrm_present),
        .sib_present(sib_present),
        .disp_present(disp_present),
        .disp_len(disp_len),
        .imm_present(imm_present),
        .imm_len(imm_len),
        .offset_present(offset_present),
        .offset_len(offset_len),
        .disp_sel(disp_sel),
        .imm_sel(imm_sel),
        .instr_length(instr_length)
    );

endmodule

// File: verification/decode_stage1_tb.sv
module decode_stage1_tb;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [31:0] eip;
        logic [15:0] cs;
        logic [127:0] ir;
        logic [15:0] opcode;
        logic opcode_size;
        logic [1:0] prefix_count;
        logic oo;
        logic rep;
        logic so;
        logic [2:0] seg;
        logic [7:0] modrm;
        logic [7:0] sib;
        logic mp;
        logic sp;
        logic dp;
        logic [2:0] dl;
        logic ip;
        logic [2:0] il;
        logic op_p;
        logic [2:0] ol;
        logic [3:0] dsel;
        logic [3:0] isel;
        logic [3:0] len;
    } expect_t;

    logic clk = 1'b0;
    logic rst_n;
    logic instr_valid;
    logic [127:0] ir;
    logic [31:0] eip;
    logic [15:0] cs;

    logic decode_valid;
    logic [31:0] eip_out;
    logic [15:0] cs_out;
    logic [127:0] ir_out;
    logic [15:0] opcode;
    logic opcode_size;
    logic [1:0] prefix_count;
    logic operand_override;
    logic repeat_prefix;
    logic segment_override;
    logic [2:0] seg_id;
    logic [7:0] modrm;
    logic [7:0] sib;
    logic modrm_present;
    logic sib_present;
    logic disp_present;
    logic [2:0] disp_len;
    logic imm_present;
    logic [2:0] imm_len;
    logic offset_present;
    logic [2:0] offset_len;
    logic [3:0] disp_sel;
    logic [3:0] imm_sel;
    logic [3:0] instr_length;

    int errors = 0;
    int checks = 0;
    int cycles = 0;
    logic have_prev = 1'b0;
    expect_t prev;

    decode_stage1 #(
        .prefix_slots(3)
    ) decode_stage1_i (.*);

    always #4 clk = ~clk;

    // ~900 cycles of tests
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= 2000) begin
            $display("timeout: tests still running after %0d cycles", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic logic is_prefix_byte(input logic [7:0] b);
        return b inside {8'h66, 8'hF2, 8'hF3, 8'h26, 8'h2E, 8'h36, 8'h3E, 8'h64, 8'h65};
    endfunction

    function automatic logic [7:0] random_prefix();
        logic [71:0] table_bytes;
        int idx;
        table_bytes = {8'h66, 8'hF2, 8'hF3, 8'h26, 8'h2E, 8'h36, 8'h3E, 8'h64, 8'h65};
        idx = int'($urandom % 9);
        return table_bytes[8*idx +: 8];
    endfunction

    function automatic logic [7:0] random_opcode();
        logic [7:0] op;
        op = 8'($urandom);
        while (is_prefix_byte(op) || op == 8'h0F) begin
            op = 8'($urandom);
        end
        return op;
    endfunction

    function automatic logic [2:0] segment_id(input logic [7:0] b);
        case (b)
            8'h2E: return 3'd1;
            8'h36: return 3'd2;
            8'h3E: return 3'd3;
            8'h64: return 3'd4;
            8'h65: return 3'd5;
            default: return 3'd0;
        endcase
    endfunction

    function automatic logic modrm_used(input logic two, input logic [7:0] op);
        if (two) begin
            return op == 8'hAF || op == 8'hB6 || op == 8'hB7;
        end
        if (op < 8'h40) begin
            return (op % 8) < 4;
        end
        return (op >= 8'h80 && op <= 8'h8B)
            || op == 8'hC6 || op == 8'hC7 || op == 8'hF6 || op == 8'hF7 || op == 8'hFF;
    endfunction

    function automatic int imm_bytes(input logic two, input logic [7:0] op, input logic oo);
        int z;
        int len;
        z = oo ? 2 : 4;
        len = 0;
        if (!two && op <= 8'h3F && op[2:0] == 3'd4) begin
            len = 1;
        end else if (!two && op <= 8'h3F && op[2:0] == 3'd5) begin
            len = z;
        end else if (!two && op inside {[8'hB0:8'hB7], 8'h80, 8'h83, 8'hC6, 8'h6A}) begin
            len = 1;
        end else if (!two && op inside {[8'hB8:8'hBF], 8'h81, 8'hC7, 8'h68}) begin
            len = z;
        end
        return len;
    endfunction

    function automatic int offset_bytes(input logic two, input logic [7:0] op, input logic oo);
        int z;
        z = oo ? 2 : 4;
        if (two) begin
            return (op >= 8'h80 && op <= 8'h8F) ? z : 0;
        end
        if (op inside {[8'h70:8'h7F], 8'hEB}) begin
            return 1;
        end
        return (op inside {8'hE8, 8'hE9}) ? z : 0;
    endfunction

    // window and expected decode from a field list
    // prefix 0 sits in pfx[7:0]
    task automatic build_window(input logic [23:0] pfx, input int np, input logic two,
                                input logic [7:0] op, input logic [7:0] mb,
                                input logic [7:0] sb, output expect_t e);
        logic [7:0] b [16];
        logic [7:0] p;
        int pos;
        int dsel;
        e = '0;
        for (int i = 0; i < 16; i++) begin
            b[i] = 8'($urandom);
        end
        pos = 0;
        for (int i = 0; i < np; i++) begin
            p = pfx[8*i +: 8];
            b[pos] = p;
            pos++;
            if (p == 8'h66) begin
                e.oo = 1'b1;
            end
            if (p == 8'hF2 || p == 8'hF3) begin
                e.rep = 1'b1;
            end
            if (p inside {8'h26, 8'h2E, 8'h36, 8'h3E, 8'h64, 8'h65}) begin
                e.so = 1'b1;
                e.seg = segment_id(p);
            end
        end
        if (two) begin
            b[pos] = 8'h0F;
            pos++;
        end
        b[pos] = op;
        b[pos + 1] = mb;
        b[pos + 2] = sb;
        for (int i = 0; i < 16; i++) begin
            e.ir[8*(15-i) +: 8] = b[i];
        end
        e.eip = $urandom;
        e.cs = 16'($urandom);
        e.opcode = {two ? 8'h0F : 8'h00, op};
        e.opcode_size = two;
        e.prefix_count = 2'(np);
        e.mp = modrm_used(two, op);
        e.sp = e.mp && mb[7:6] < 2'd3 && mb[2:0] == 3'd4;
        if (e.mp && mb[7:6] == 2'd1) begin
            e.dl = 3'd1;
        end else if (e.mp && mb[7:6] == 2'd2) begin
            e.dl = 3'd4;
        end else if (e.mp && mb[7:6] == 2'd0
                     && (mb[2:0] == 3'd5 || (e.sp && sb[2:0] == 3'd5))) begin
            e.dl = 3'd4;
        end
        e.dp = (e.dl != 3'd0);
        e.modrm = e.mp ? mb : 8'h00;
        e.sib = e.sp ? sb : 8'h00;
        e.il = 3'(imm_bytes(two, op, e.oo));
        e.ip = (e.il != 3'd0);
        e.ol = 3'(offset_bytes(two, op, e.oo));
        e.op_p = (e.ol != 3'd0);
        dsel = np + (two ? 2 : 1) + int'(e.mp) + int'(e.sp);
        e.dsel = 4'(dsel);
        e.isel = 4'(dsel + int'(e.dl));
        e.len = 4'(dsel + int'(e.dl) + int'(e.il) + int'(e.ol));
    endtask

    task automatic compare_field(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %0h exp %0h", name, got, exp);
        end
    endtask

    task automatic check_result(input expect_t e);
        compare_field("decode_valid", 128'(decode_valid), 128'(1'b1));
        compare_field("eip_out", 128'(eip_out), 128'(e.eip));
        compare_field("cs_out", 128'(cs_out), 128'(e.cs));
        compare_field("ir_out", ir_out, e.ir);
        compare_field("opcode", 128'(opcode), 128'(e.opcode));
        compare_field("opcode_size", 128'(opcode_size), 128'(e.opcode_size));
        compare_field("prefix_count", 128'(prefix_count), 128'(e.prefix_count));
        compare_field("operand_override", 128'(operand_override), 128'(e.oo));
        compare_field("repeat_prefix", 128'(repeat_prefix), 128'(e.rep));
        compare_field("segment_override", 128'(segment_override), 128'(e.so));
        compare_field("seg_id", 128'(seg_id), 128'(e.seg));
        compare_field("modrm", 128'(modrm), 128'(e.modrm));
        compare_field("sib", 128'(sib), 128'(e.sib));
        compare_field("modrm_present", 128'(modrm_present), 128'(e.mp));
        compare_field("sib_present", 128'(sib_present), 128'(e.sp));
        compare_field("disp_present", 128'(disp_present), 128'(e.dp));
        compare_field("disp_len", 128'(disp_len), 128'(e.dl));
        compare_field("imm_present", 128'(imm_present), 128'(e.ip));
        compare_field("imm_len", 128'(imm_len), 128'(e.il));
        compare_field("offset_present", 128'(offset_present), 128'(e.op_p));
        compare_field("offset_len", 128'(offset_len), 128'(e.ol));
        compare_field("disp_sel", 128'(disp_sel), 128'(e.dsel));
        compare_field("imm_sel", 128'(imm_sel), 128'(e.isel));
        compare_field("instr_length", 128'(instr_length), 128'(e.len));
    endtask

    // result of the previous window shows up one edge after this one is driven
    task automatic send_window(input expect_t e);
        @(posedge clk);
        instr_valid <= 1'b1;
        ir <= e.ir;
        eip <= e.eip;
        cs <= e.cs;
        @(negedge clk);
        if (have_prev) begin
            check_result(prev);
        end
        prev = e;
        have_prev = 1'b1;
    endtask

    task automatic finish_burst();
        @(posedge clk);
        instr_valid <= 1'b0;
        @(negedge clk);
        if (have_prev) begin
            check_result(prev);
        end
        have_prev = 1'b0;
        @(negedge clk);
        compare_field("decode_valid", 128'(decode_valid), 128'(1'b0));
    endtask

    task automatic reset_values();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        compare_field("decode_valid", 128'(decode_valid), 128'd0);
        compare_field("modrm_present", 128'(modrm_present), 128'd0);
        compare_field("sib_present", 128'(sib_present), 128'd0);
        compare_field("disp_present", 128'(disp_present), 128'd0);
        compare_field("imm_present", 128'(imm_present), 128'd0);
        compare_field("offset_present", 128'(offset_present), 128'd0);
        compare_field("opcode", 128'(opcode), 128'd0);
        compare_field("instr_length", 128'(instr_length), 128'd0);
        compare_field("ir_out", ir_out, 128'd0);
    endtask

    task automatic prefix_sequences();
        expect_t e;
        logic [23:0] pfx;
        for (int n = 0; n < 40; n++) begin
            pfx = {random_prefix(), random_prefix(), random_prefix()};
            build_window(pfx, n % 4, 1'b0, 8'h90, 8'h00, 8'h00, e);
            send_window(e);
        end
        // later segment prefix overrides
        build_window({8'h65, 8'h66, 8'h26}, 3, 1'b0, 8'h90, 8'h00, 8'h00, e);
        send_window(e);
        build_window({8'h00, 8'h3E, 8'h2E}, 2, 1'b0, 8'h90, 8'h00, 8'h00, e);
        send_window(e);
        // prefix bytes that follow the opcode
        build_window({8'h00, 8'h00, 8'hF3}, 1, 1'b0, 8'h40, 8'h66, 8'h2E, e);
        send_window(e);
        build_window(24'h0, 0, 1'b1, 8'h84, 8'h64, 8'hF2, e);
        send_window(e);
        finish_burst();
    endtask

    task automatic opcode_extraction();
        expect_t e;
        logic [23:0] pfx;
        logic two;
        for (int np = 0; np < 4; np++) begin
            for (int k = 0; k < 8; k++) begin
                pfx = {random_prefix(), random_prefix(), random_prefix()};
                two = k[0];
                build_window(pfx, np, two, two ? 8'($urandom) : random_opcode(),
                             8'($urandom), 8'($urandom), e);
                send_window(e);
            end
        end
        finish_burst();
    endtask

    task automatic addressing_modes();
        expect_t e;
        logic [7:0] mb;
        logic [7:0] sb;
        for (int m = 0; m < 32; m++) begin
            for (int s = 0; s < 2; s++) begin
                mb = {2'(m / 8), 3'($urandom), 3'(m % 8)};
                sb = {5'($urandom), s ? 3'd5 : 3'd1};
                case (m % 3)
                    0: build_window(24'h0, 0, 1'b0, 8'h8B, mb, sb, e);
                    1: build_window({16'h0, random_prefix()}, 1, 1'b1, 8'hAF, mb, sb, e);
                    default: build_window(24'h0, 0, 1'b0, 8'h81, mb, sb, e);
                endcase
                send_window(e);
            end
        end
        finish_burst();
    endtask

    task automatic immediate_fields();
        expect_t e;
        for (int op = 0; op < 256; op++) begin
            if (!is_prefix_byte(8'(op)) && op != 15) begin
                for (int o = 0; o < 2; o++) begin
                    build_window(o == 1 ? 24'h66 : 24'h0, o, 1'b0, 8'(op), 8'h45, 8'h00, e);
                    send_window(e);
                end
            end
        end
        for (int op = 128; op < 144; op++) begin
            for (int o = 0; o < 2; o++) begin
                build_window(o == 1 ? 24'h66 : 24'h0, o, 1'b1, 8'(op), 8'h00, 8'h00, e);
                send_window(e);
            end
        end
        finish_burst();
    endtask

    task automatic random_stream();
        expect_t e;
        logic two;
        logic [7:0] op;
        for (int n = 0; n < 200; n++) begin
            two = 1'($urandom);
            op = two ? 8'($urandom) : random_opcode();
            build_window({random_prefix(), random_prefix(), random_prefix()},
                         int'($urandom % 4), two, op, 8'($urandom), 8'($urandom), e);
            send_window(e);
        end
        finish_burst();
    endtask

    initial begin
        void'($urandom(74847));
        rst_n = 1'b0;
        instr_valid = 1'b0;
        ir = '0;
        eip = '0;
        cs = '0;
        reset_values();
        prefix_sequences();
        opcode_extraction();
        addressing_modes();
        immediate_fields();
        random_stream();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
logic/decode_pkg.sv
logic/decode_if.sv
logic/opcode_locator.sv
logic/addressing_decoder.sv
logic/immediate_decoder.sv
logic/length_combiner.sv
logic/decode_stage1.sv
verification/decode_stage1_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f sim.f --top-module decode_stage1_tb -o decode_sim
out=$(./obj_dir/decode_sim)
echo "$out"
if echo "$out" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
exit 1
